/* Bender.yml */
package:
  name: calculator

sources:
  - key_pkg.sv
  - calc_pkg.sv
  - add_sub_unit.sv
  - shift_add_mult.sv
  - entry_controller.sv
  - calculator_top.sv
  - target: test
    files:
      - calc_checker.sv
      - tb_calculator.sv

/* add_sub_unit.sv */
// Single-cycle registered adder-subtractor with start and finish pulses
`default_nettype none
`timescale 1ns/100ps

module add_sub_unit #(
    parameter int WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  nRST,
    input  logic                  start,
    input  calc_pkg::addsub_req_t req,
    output logic [WIDTH-1:0]      result,
    output logic                  finish
);

    logic [WIDTH-1:0] op_a;
    logic [WIDTH-1:0] op_b;

    assign op_a = req.operand_a[WIDTH-1:0];
    assign op_b = req.operand_b[WIDTH-1:0];

    // Done one cycle after the start pulse
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            finish <= 1'b0;
        end else begin
            finish <= start;
        end
    end

    // Wraps modulo 2**WIDTH in both directions
    always_ff @(posedge clk) begin
        if (start) begin
            if (req.subtract) begin
                result <= op_a - op_b;
            end else begin
                result <= op_a + op_b;
            end
        end
    end

endmodule

`default_nettype wire

/* calc_checker.sv */
// Testbench checker: entry model, key_read and result comparison, error summary
`default_nettype none
`timescale 1ns/100ps

module calc_checker #(
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             nRST,
    input  logic [3:0]       keypad_input,
    input  logic             read_input,
    input  logic [2:0]       operator_input,
    input  logic             equal_input,
    input  logic             key_read,
    input  logic             complete,
    input  logic [WIDTH-1:0] display_output,
    input  int               timeouts,
    input  logic             report,
    output int               errors
);

    import key_pkg::*;

    logic [WIDTH-1:0] op1;
    logic [WIDTH-1:0] op2;
    logic [2:0]       op;
    logic             second;
    logic             exp_key_read;
    logic [WIDTH-1:0] exp_display;
    logic             pending;
    logic [WIDTH-1:0] pend_value;
    logic [WIDTH-1:0] pend_a;
    logic [WIDTH-1:0] pend_b;
    logic [2:0]       pend_op;
    logic             op_key;
    int               value_errors = 0;
    int               protocol_errors = 0;

    assign errors = value_errors + protocol_errors;
    assign op_key = (operator_input == OP_ADD) || (operator_input == OP_SUB) ||
                    (operator_input == OP_MUL);

    // Unsigned, wraps at WIDTH bits
    function automatic logic [WIDTH-1:0] apply_op(input logic [2:0] code,
                                                  input logic [WIDTH-1:0] a,
                                                  input logic [WIDTH-1:0] b);
        case (code)
            OP_ADD:  apply_op = a + b;
            OP_SUB:  apply_op = a - b;
            default: apply_op = a * b;
        endcase
    endfunction

    function automatic string op_symbol(input logic [2:0] code);
        op_symbol = (code == OP_ADD) ? "+" : ((code == OP_SUB) ? "-" : "*");
    endfunction

    always @(negedge clk or negedge nRST) begin
        if (!nRST) begin
            op1          <= '0;
            op2          <= '0;
            op           <= OP_NONE;
            second       <= 1'b0;
            exp_key_read <= 1'b0;
            exp_display  <= '0;
            pending      <= 1'b0;
        end else begin
            if (key_read !== exp_key_read) begin
                protocol_errors++;
                $display("Error key_read: expected %0b actual %0b", exp_key_read, key_read);
            end
            if (complete === 1'b1) begin
                if (!pending) begin
                    protocol_errors++;
                    $display("Unexpected complete pulse while no result was pending");
                end else if (display_output !== pend_value) begin
                    value_errors++;
                    $display("Error expr %0d %s %0d: expected %0d actual %0d", pend_a,
                             op_symbol(pend_op), pend_b, pend_value, display_output);
                end
                pending     <= 1'b0;
                exp_display <= display_output;
            end else if (display_output !== exp_display) begin
                value_errors++;
                $display("Error display_hold: expected %0d actual %0d", exp_display,
                         display_output);
                exp_display <= display_output;
            end

            // Accepted strobes, seen one cycle ahead of key_read
            exp_key_read <= 1'b0;
            if (!second) begin
                if (op_key) begin
                    op           <= operator_input;
                    second       <= 1'b1;
                    exp_key_read <= 1'b1;
                end else if (read_input) begin
                    op1          <= op1 * 10 + keypad_input;
                    exp_key_read <= 1'b1;
                end
            end else if (equal_input) begin
                pend_value   <= apply_op(op, op1, op2);
                pend_a       <= op1;
                pend_b       <= op2;
                pend_op      <= op;
                pending      <= 1'b1;
                op1          <= '0;
                op2          <= '0;
                second       <= 1'b0;
                exp_key_read <= 1'b1;
            end else if (read_input) begin
                op2          <= op2 * 10 + keypad_input;
                exp_key_read <= 1'b1;
            end
        end
    end

    always @(posedge report) begin
        $display("Checker summary: %0d value errors, %0d protocol errors, %0d timeouts",
                 value_errors, protocol_errors, timeouts);
    end

endmodule

`default_nettype wire

/* calc_pkg.sv */
// Controller state encoding and request bundles for the arithmetic units
`default_nettype none

package calc_pkg;

    // Upper bound on the WIDTH parameter of every module
    localparam int MAX_WIDTH = 32;

    typedef enum logic [3:0] {
        WAIT_OP1,
        WAIT_MULT_OP1,
        ADD_KEY_OP1,
        WAIT_OP2,
        WAIT_MULT_OP2,
        ADD_KEY_OP2,
        SEND_TO_COMPUTE,
        WAIT_COMPUTE,
        SHOW_RESULT_ADDSUB,
        SHOW_RESULT_MULT
    } ctrl_state_e;

    // Operands sit in the low WIDTH bits, upper bits zero
    typedef struct packed {
        logic [MAX_WIDTH-1:0] operand_a;
        logic [MAX_WIDTH-1:0] operand_b;
        logic                 subtract;
    } addsub_req_t;

    typedef struct packed {
        logic [MAX_WIDTH-1:0] multiplicand;
        logic [MAX_WIDTH-1:0] multiplier;
    } mult_req_t;

endpackage

`default_nettype wire

/* calculator_top.sv */
// Calculator core: key bundling, entry FSM, adder-subtractor and multiplier
`default_nettype none
`timescale 1ns/100ps

module calculator_top #(
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             nRST,
    input  logic [3:0]       keypad_input,
    input  logic             read_input,
    input  logic [2:0]       operator_input,
    input  logic             equal_input,
    output logic             key_read,
    output logic             complete,
    output logic [WIDTH-1:0] display_output
);

    import key_pkg::*;
    import calc_pkg::*;

    key_event_t       key;
    addsub_req_t      addsub_req;
    mult_req_t        mult_req;
    logic             start_addsub;
    logic             start_mult;
    logic             addsub_finish;
    logic             mult_finish;
    logic [WIDTH-1:0] addsub_result;
    logic [WIDTH-1:0] mult_result;

    assign key = '{
        digit:       keypad_input,
        digit_valid: read_input,
        op:          op_code_e'(operator_input),
        equal:       equal_input
    };

    entry_controller #(.WIDTH(WIDTH)) u_ctrl (
        .clk            (clk),
        .nRST           (nRST),
        .key            (key),
        .addsub_req     (addsub_req),
        .start_addsub   (start_addsub),
        .addsub_result  (addsub_result),
        .addsub_finish  (addsub_finish),
        .mult_req       (mult_req),
        .start_mult     (start_mult),
        .mult_result    (mult_result),
        .mult_finish    (mult_finish),
        .key_read       (key_read),
        .complete       (complete),
        .display_output (display_output)
    );

    add_sub_unit #(.WIDTH(WIDTH)) u_addsub (
        .clk    (clk),
        .nRST   (nRST),
        .start  (start_addsub),
        .req    (addsub_req),
        .result (addsub_result),
        .finish (addsub_finish)
    );

    shift_add_mult #(.WIDTH(WIDTH)) u_mult (
        .clk    (clk),
        .nRST   (nRST),
        .start  (start_mult),
        .req    (mult_req),
        .result (mult_result),
        .finish (mult_finish)
    );

endmodule

`default_nettype wire

/* entry_controller.sv */
// Operand entry FSM: digit accumulation, operator latch, dispatch and result display
`default_nettype none
`timescale 1ns/100ps

module entry_controller #(
    parameter int WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  nRST,
    input  key_pkg::key_event_t   key,

    output calc_pkg::addsub_req_t addsub_req,
    output logic                  start_addsub,
    input  logic [WIDTH-1:0]      addsub_result,
    input  logic                  addsub_finish,

    output calc_pkg::mult_req_t   mult_req,
    output logic                  start_mult,
    input  logic [WIDTH-1:0]      mult_result,
    input  logic                  mult_finish,

    output logic                  key_read,
    output logic                  complete,
    output logic [WIDTH-1:0]      display_output
);

    import key_pkg::*;
    import calc_pkg::*;

    ctrl_state_e      state;
    ctrl_state_e      next_state;
    op_code_e         latched_op;
    logic [3:0]       latched_digit;
    logic [WIDTH-1:0] operand1;
    logic [WIDTH-1:0] operand2;

    logic op_valid;
    logic accept_digit;
    logic accept_op;
    logic accept_equal;
    logic send_addsub;
    logic send_mult;

    // Negate and undefined codes are not operators here
    assign op_valid = key.op inside {OP_ADD, OP_SUB, OP_MUL};

    assign send_addsub = (state == SEND_TO_COMPUTE) &&
                         (latched_op == OP_ADD || latched_op == OP_SUB);
    assign send_mult   = (state == SEND_TO_COMPUTE) && (latched_op == OP_MUL);

    always_comb begin
        next_state   = state;
        accept_digit = 1'b0;
        accept_op    = 1'b0;
        accept_equal = 1'b0;

        case (state)
            WAIT_OP1: begin
                // Operator wins over a digit in the same cycle
                if (op_valid) begin
                    accept_op  = 1'b1;
                    next_state = WAIT_OP2;
                end else if (key.digit_valid) begin
                    accept_digit = 1'b1;
                    next_state   = WAIT_MULT_OP1;
                end
            end

            WAIT_MULT_OP1: begin
                if (mult_finish) begin
                    next_state = ADD_KEY_OP1;
                end
            end

            ADD_KEY_OP1: next_state = WAIT_OP1;

            WAIT_OP2: begin
                if (key.equal) begin
                    accept_equal = 1'b1;
                    next_state   = SEND_TO_COMPUTE;
                end else if (key.digit_valid) begin
                    accept_digit = 1'b1;
                    next_state   = WAIT_MULT_OP2;
                end
            end

            WAIT_MULT_OP2: begin
                if (mult_finish) begin
                    next_state = ADD_KEY_OP2;
                end
            end

            ADD_KEY_OP2: next_state = WAIT_OP2;

            SEND_TO_COMPUTE: next_state = WAIT_COMPUTE;

            WAIT_COMPUTE: begin
                if (addsub_finish) begin
                    next_state = SHOW_RESULT_ADDSUB;
                end else if (mult_finish) begin
                    next_state = SHOW_RESULT_MULT;
                end
            end

            SHOW_RESULT_ADDSUB, SHOW_RESULT_MULT: next_state = WAIT_OP1;

            default: next_state = WAIT_OP1;
        endcase
    end

    // Request payload, held until the next start
    always_ff @(posedge clk) begin
        if (accept_digit) begin
            latched_digit <= key.digit;
            // Shift the operand being entered one decimal place
            if (state == WAIT_OP1) begin
                mult_req.multiplicand <= MAX_WIDTH'(operand1);
            end else begin
                mult_req.multiplicand <= MAX_WIDTH'(operand2);
            end
            mult_req.multiplier <= MAX_WIDTH'(10);
        end else if (send_mult) begin
            mult_req.multiplicand <= MAX_WIDTH'(operand1);
            mult_req.multiplier   <= MAX_WIDTH'(operand2);
        end

        if (send_addsub) begin
            addsub_req.operand_a <= MAX_WIDTH'(operand1);
            addsub_req.operand_b <= MAX_WIDTH'(operand2);
            addsub_req.subtract  <= (latched_op == OP_SUB);
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= WAIT_OP1;
            latched_op     <= OP_NONE;
            operand1       <= '0;
            operand2       <= '0;
            start_addsub   <= 1'b0;
            start_mult     <= 1'b0;
            key_read       <= 1'b0;
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            state        <= next_state;
            key_read     <= accept_digit | accept_op | accept_equal;
            start_mult   <= accept_digit | send_mult;
            start_addsub <= send_addsub;
            complete     <= 1'b0;

            if (accept_op) begin
                latched_op <= key.op;
            end

            case (state)
                WAIT_MULT_OP1: begin
                    if (mult_finish) begin
                        operand1 <= mult_result;
                    end
                end

                ADD_KEY_OP1: operand1 <= operand1 + WIDTH'(latched_digit);

                WAIT_MULT_OP2: begin
                    if (mult_finish) begin
                        operand2 <= mult_result;
                    end
                end

                ADD_KEY_OP2: operand2 <= operand2 + WIDTH'(latched_digit);

                // Result shows up together with the complete pulse
                WAIT_COMPUTE: begin
                    if (addsub_finish) begin
                        display_output <= addsub_result;
                        complete       <= 1'b1;
                    end else if (mult_finish) begin
                        display_output <= mult_result;
                        complete       <= 1'b1;
                    end
                end

                // Next expression starts from zero
                SHOW_RESULT_ADDSUB, SHOW_RESULT_MULT: begin
                    operand1   <= '0;
                    operand2   <= '0;
                    latched_op <= OP_NONE;
                end

                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* files.f */
key_pkg.sv
calc_pkg.sv
add_sub_unit.sv
shift_add_mult.sv
entry_controller.sv
calculator_top.sv
calc_checker.sv
tb_calculator.sv

/* key_pkg.sv */
// Keypad operator codes and the per-cycle key event bundle
`default_nettype none

package key_pkg;

    // Operator keys as they arrive on operator_input
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_NEG  = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } op_code_e;

    // One cycle of keypad activity, 9 bits
    typedef struct packed {
        logic [3:0] digit;
        logic       digit_valid;
        op_code_e   op;
        logic       equal;
    } key_event_t;

endpackage

`default_nettype wire

/* shift_add_mult.sv */
// Iterative shift-and-add multiplier, one multiplier bit per cycle
`default_nettype none
`timescale 1ns/100ps

module shift_add_mult #(
    parameter int WIDTH = 16
) (
    input  logic                clk,
    input  logic                nRST,
    input  logic                start,
    input  calc_pkg::mult_req_t req,
    output logic [WIDTH-1:0]    result,
    output logic                finish
);

    localparam int CNT_W = $clog2(WIDTH);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(WIDTH - 1);

    logic             busy;
    logic [CNT_W-1:0] step;
    logic             last_step;
    logic [WIDTH-1:0] mcand;
    logic [WIDTH-1:0] mplier;
    logic [WIDTH-1:0] acc;
    logic [WIDTH-1:0] acc_next;

    assign last_step = (step == LAST_STEP);

    // Partial product for the current multiplier LSB
    assign acc_next = mplier[0] ? acc + mcand : acc;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy   <= 1'b0;
            step   <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy <= 1'b1;
                    step <= '0;
                end
            end else begin
                step <= step + 1'b1;
                if (last_step) begin
                    busy   <= 1'b0;
                    finish <= 1'b1;
                end
            end
        end
    end

    // Starts while busy are ignored
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            mcand  <= req.multiplicand[WIDTH-1:0];
            mplier <= req.multiplier[WIDTH-1:0];
            acc    <= '0;
        end else if (busy) begin
            acc    <= acc_next;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            if (last_step) begin
                result <= acc_next;
            end
        end
    end

endmodule

`default_nettype wire

/* tb_calculator.sv */
// Testbench top: clock, reset, LFSR keypad stimulus, DUT and checker instances
`default_nettype none
`timescale 1ns/100ps

module tb_calculator;

    import key_pkg::*;

    localparam int WIDTH       = 16;
    localparam int GAP         = WIDTH + 8;
    localparam int WAIT_LIMIT  = 4 * WIDTH + 20;
    localparam int DRIVE_DELAY = 4;

    logic             clk;
    logic             nRST;
    logic [3:0]       keypad_input;
    logic             read_input;
    logic [2:0]       operator_input;
    logic             equal_input;
    logic             key_read;
    logic             complete;
    logic [WIDTH-1:0] display_output;
    logic [31:0]      lfsr;
    logic             report;
    int               timeouts;
    int               checker_errors;

    calculator_top #(.WIDTH(WIDTH)) uut (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .key_read       (key_read),
        .complete       (complete),
        .display_output (display_output)
    );

    calc_checker #(.WIDTH(WIDTH)) u_check (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .key_read       (key_read),
        .complete       (complete),
        .display_output (display_output),
        .timeouts       (timeouts),
        .report         (report),
        .errors         (checker_errors)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Right-shift Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(posedge clk);
    endtask

    // One-cycle strobe on the selected key input
    task automatic pulse_key(input logic [3:0] digit, input logic [2:0] code, input logic eq);
        @(posedge clk);
        #DRIVE_DELAY;
        keypad_input   = digit;
        read_input     = (code == OP_NONE) && !eq;
        operator_input = code;
        equal_input    = eq;
        @(posedge clk);
        #DRIVE_DELAY;
        read_input     = 1'b0;
        operator_input = OP_NONE;
        equal_input    = 1'b0;
    endtask

    task automatic wait_for_pulse(input logic on_complete, input string what);
        logic found;
        found = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !found; n++) begin
            @(negedge clk);
            found = on_complete ? complete : key_read;
        end
        if (!found) begin
            timeouts++;
            $display("Timeout: the %s strobe got no %s within %0d cycles", what,
                     on_complete ? "complete" : "key_read", WAIT_LIMIT);
        end
    endtask

    task automatic press(input logic [3:0] digit, input logic [2:0] code, input logic eq);
        string what;
        what = eq ? "equal" : ((code != OP_NONE) ? "operator" : "digit");
        pulse_key(digit, code, eq);
        wait_for_pulse(1'b0, what);
        if (eq) begin
            wait_for_pulse(1'b1, what);
        end
        idle(GAP);
    endtask

    // Decimal digits, most significant first
    task automatic enter_number(input int value);
        int div;
        div = 1;
        while (div * 10 <= value) begin
            div = div * 10;
        end
        while (div > 0) begin
            press(4'((value / div) % 10), OP_NONE, 1'b0);
            div = div / 10;
        end
    endtask

    task automatic run_expression(input int a, input logic [2:0] code, input int b);
        enter_number(a);
        press(4'd0, code, 1'b0);
        enter_number(b);
        press(4'd0, OP_NONE, 1'b1);
    endtask

    task automatic random_expression();
        int count;
        int value;
        int code;
        draw_bits(3, count);
        repeat (count % 5 + 1) begin
            draw_bits(4, value);
            press(4'(value % 10), OP_NONE, 1'b0);
        end
        draw_bits(2, code);
        press(4'd0, 3'(code % 3 + 2), 1'b0);
        draw_bits(3, count);
        repeat (count % 5 + 1) begin
            draw_bits(4, value);
            press(4'(value % 10), OP_NONE, 1'b0);
        end
        press(4'd0, OP_NONE, 1'b1);
    endtask

    initial begin
        nRST           = 1'b0;
        keypad_input   = 4'd0;
        read_input     = 1'b0;
        operator_input = OP_NONE;
        equal_input    = 1'b0;
        lfsr           = 32'h81fb998d;
        report         = 1'b0;
        timeouts       = 0;
        repeat (10) @(posedge clk);
        #DRIVE_DELAY;
        nRST = 1'b1;

        // Quiet outputs right after reset
        idle(20);

        run_expression(99999, OP_ADD, 88888);
        run_expression(12, OP_SUB, 345);
        run_expression(4321, OP_MUL, 567);

        // Equal before any operator is dropped
        enter_number(42);
        pulse_key(4'd0, OP_NONE, 1'b1);
        idle(WAIT_LIMIT);
        press(4'd0, OP_ADD, 1'b0);
        enter_number(8);
        press(4'd0, OP_NONE, 1'b1);

        repeat (30) random_expression();

        report = 1'b1;
        #1;
        if (timeouts == 0 && checker_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
